//--- design/iob_apb_pkg.sv
`default_nettype none

package iob_apb_pkg;

   // Bus widths shared by the bridge, the slave and the testbench
   localparam int ADDR_W = 32;          // Byte address
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;  // One strobe per byte lane

   // IOb request from the master
   typedef struct packed {
      logic              avalid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;  // Zero means read
   } iob_req_t;

   // IOb response back to the master
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;  // One-cycle pulse
      logic              ready;
   } iob_resp_t;

   // APB master outputs
   typedef struct packed {
      logic              sel;
      logic              enable;
      logic [ADDR_W-1:0] addr;
      logic              write;
      logic [STRB_W-1:0] wstrb;
      logic [DATA_W-1:0] wdata;
   } apb_req_t;

   // APB slave response
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              ready;
   } apb_resp_t;

endpackage

`default_nettype wire

//--- design/apb_wait_timer.sv
`timescale 1ns/1ns
`default_nettype none

module apb_wait_timer #(
   parameter int WAIT_STATES = 2  // 0 to 15
) (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic access_i,  // APB access phase in progress
   output logic done_o     // Access may complete in this cycle
);

   // At least one bit so that zero wait states still builds
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   logic [CNT_W-1:0] cnt_q;

   // Count 0 is the first access cycle
   assign done_o = access_i && (cnt_q == CNT_W'(WAIT_STATES));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (!access_i || done_o) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // Completion comes exactly WAIT_STATES cycles into the access phase
   a_done_after_waits: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(access_i) |-> ##WAIT_STATES done_o)
      else $error("Wait timer done not WAIT_STATES cycles into the access phase");

endmodule

`default_nettype wire

//--- design/apb_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module apb_regfile #(
   parameter int WAIT_STATES = 2,
   parameter int N_REGS      = 16  // Power of two, up to 256
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  iob_apb_pkg::apb_req_t  apb_req_i,
   output iob_apb_pkg::apb_resp_t apb_resp_o
);

   localparam int OFS_W   = $clog2(iob_apb_pkg::STRB_W);      // Byte offset bits
   localparam int WADDR_W = iob_apb_pkg::ADDR_W - OFS_W;
   localparam int IDX_W   = (N_REGS > 1) ? $clog2(N_REGS) : 1;

   logic [iob_apb_pkg::DATA_W-1:0] regs_q [N_REGS];

   logic               access;
   logic               done;
   logic [WADDR_W-1:0] word_addr;
   logic               in_range;
   logic [IDX_W-1:0]   idx;

   assign access    = apb_req_i.sel & apb_req_i.enable;
   assign word_addr = apb_req_i.addr[iob_apb_pkg::ADDR_W-1:OFS_W];
   assign in_range  = word_addr < WADDR_W'(N_REGS);
   assign idx       = word_addr[IDX_W-1:0];

   // Stretches the access phase by WAIT_STATES cycles
   apb_wait_timer #(
      .WAIT_STATES(WAIT_STATES)
   ) i_timer (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .access_i(access),
      .done_o  (done)
   );

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < N_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (done && apb_req_i.write && in_range) begin
         for (int b = 0; b < iob_apb_pkg::STRB_W; b++) begin
            if (apb_req_i.wstrb[b]) begin
               regs_q[idx][8*b +: 8] <= apb_req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // Words past the bank read as zero
   assign apb_resp_o.rdata = in_range ? regs_q[idx] : '0;
   assign apb_resp_o.ready = done;

endmodule

`default_nettype wire

//--- design/iob2apb.sv
`timescale 1ns/1ns
`default_nettype none

module iob2apb (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  iob_apb_pkg::iob_req_t  iob_req_i,
   output iob_apb_pkg::iob_resp_t iob_resp_o,
   output iob_apb_pkg::apb_req_t  apb_req_o,
   input  iob_apb_pkg::apb_resp_t apb_resp_i
);

   localparam logic PH_IDLE = 1'b0;
   localparam logic PH_XFER = 1'b1;

   logic phase_q;
   logic start;   // Request accepted this cycle
   logic finish;  // Slave completes the access phase

   // Control state
   logic sel_q;
   logic enable_q;
   logic ready_q;
   logic rvalid_q;

   // Registered payload
   logic [iob_apb_pkg::ADDR_W-1:0] addr_q;
   logic                           write_q;
   logic [iob_apb_pkg::STRB_W-1:0] wstrb_q;
   logic [iob_apb_pkg::DATA_W-1:0] wdata_q;
   logic [iob_apb_pkg::DATA_W-1:0] rdata_q;

   assign start  = (phase_q == PH_IDLE) && iob_req_i.avalid && ready_q;
   assign finish = (phase_q == PH_XFER) && enable_q && apb_resp_i.ready;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         phase_q  <= PH_IDLE;
         sel_q    <= 1'b0;
         enable_q <= 1'b0;
         ready_q  <= 1'b1;  // Able to take a request right after reset
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= 1'b0;
         case (phase_q)
            PH_IDLE: begin
               if (start) begin
                  phase_q <= PH_XFER;
                  ready_q <= 1'b0;  // Busy until the response
               end
            end
            default: begin
               if (!sel_q) begin
                  sel_q <= 1'b1;  // Setup phase
               end else if (!enable_q) begin
                  enable_q <= 1'b1;  // Access phase
               end else if (apb_resp_i.ready) begin
                  sel_q    <= 1'b0;
                  enable_q <= 1'b0;
                  rvalid_q <= 1'b1;
                  ready_q  <= 1'b1;
                  phase_q  <= PH_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         addr_q  <= iob_req_i.addr;
         write_q <= |iob_req_i.wstrb;
         wstrb_q <= iob_req_i.wstrb;
         wdata_q <= iob_req_i.wdata;
      end
      if (finish) begin
         rdata_q <= apb_resp_i.rdata;  // Captured on writes as well
      end
   end

   assign apb_req_o = '{
      sel:    sel_q,
      enable: enable_q,
      addr:   addr_q,
      write:  write_q,
      wstrb:  wstrb_q,
      wdata:  wdata_q
   };

   assign iob_resp_o = '{
      rdata:  rdata_q,
      rvalid: rvalid_q,
      ready:  ready_q
   };

   a_enable_needs_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_req_o.enable |-> apb_req_o.sel)
      else $error("APB enable high without sel");

   // The request must not move while the slave is still inserting wait states
   a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (apb_req_o.sel && !apb_resp_i.ready) |=>
         ($stable(apb_req_o.addr) && $stable(apb_req_o.wdata) &&
          $stable(apb_req_o.wstrb) && $stable(apb_req_o.write)))
      else $error("APB request changed during a transfer");

   a_rvalid_with_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_resp_o.rvalid |-> iob_resp_o.ready)
      else $error("IOb rvalid while ready is low");

endmodule

`default_nettype wire

//--- design/iob_apb_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module iob_apb_subsys #(
   parameter int WAIT_STATES = 2,  // Slave wait states per access
   parameter int N_REGS      = 16  // Register bank depth in words
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  iob_apb_pkg::iob_req_t  iob_req_i,
   output iob_apb_pkg::iob_resp_t iob_resp_o
);

   iob_apb_pkg::apb_req_t  apb_req;
   iob_apb_pkg::apb_resp_t apb_resp;

   // IOb to APB bridge
   iob2apb i_bridge (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .iob_req_i (iob_req_i),
      .iob_resp_o(iob_resp_o),
      .apb_req_o (apb_req),
      .apb_resp_i(apb_resp)
   );

   // APB register bank with its wait-state timer
   apb_regfile #(
      .WAIT_STATES(WAIT_STATES),
      .N_REGS     (N_REGS)
   ) i_regfile (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .apb_req_i (apb_req),
      .apb_resp_o(apb_resp)
   );

endmodule

`default_nettype wire

//--- verif/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
   parameter int WAIT_STATES = 2,
   parameter int N_REGS      = 16
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  iob_apb_pkg::iob_req_t  iob_req_i,
   input  iob_apb_pkg::iob_resp_t iob_resp_i,
   input  logic [2:0]             test_id_i,
   output int                     value_errs_o,
   output int                     proto_errs_o,
   output int                     resp_cnt_o
);

   logic [iob_apb_pkg::DATA_W-1:0] shadow [N_REGS];  // Expected register contents

   logic [iob_apb_pkg::DATA_W-1:0] exp_rdata;
   logic [iob_apb_pkg::ADDR_W-1:0] exp_addr;
   logic                           exp_write;
   logic [2:0]                     exp_test;
   logic                           pending;      // Request accepted, no rvalid yet
   logic                           check_reset;  // First sample after reset
   logic                           prev_rvalid;
   int                             sample;
   int                             acc_sample;
   int                             latency;

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "reset_read";
         3'd2:    return "full_write";
         3'd3:    return "partial_write";
         3'd4:    return "out_of_range";
         3'd5:    return "random";
         default: return "unknown";
      endcase
   endfunction

   // Expected read value of a request; a write also merges its bytes into the shadow copy
   function automatic logic [iob_apb_pkg::DATA_W-1:0] ref_access(
      input logic [iob_apb_pkg::ADDR_W-1:0] addr,
      input logic [iob_apb_pkg::DATA_W-1:0] wdata,
      input logic [iob_apb_pkg::STRB_W-1:0] wstrb
   );
      logic [iob_apb_pkg::ADDR_W-1:0] word;
      logic [iob_apb_pkg::DATA_W-1:0] old;
      word = addr / iob_apb_pkg::ADDR_W'(iob_apb_pkg::STRB_W);
      if (word >= iob_apb_pkg::ADDR_W'(N_REGS)) begin
         return '0;  // Nothing stored past the bank
      end
      old = shadow[word];
      for (int b = 0; b < iob_apb_pkg::STRB_W; b++) begin
         if (wstrb[b]) begin
            shadow[word][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      return old;
   endfunction

   task automatic report_protocol(input string msg);
      $display("Error: %s (sample %0d)", msg, sample);
      proto_errs_o++;
   endtask

   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < N_REGS; i++) begin
            shadow[i] = '0;
         end
         pending     = 1'b0;
         check_reset = 1'b1;
         prev_rvalid = 1'b0;
         sample      = 0;
      end else begin
         sample = sample + 1;
         if (check_reset) begin
            if (!iob_resp_i.ready || iob_resp_i.rvalid) begin
               report_protocol("ready low or rvalid high right after reset");
            end
            check_reset = 1'b0;
         end
         if (iob_resp_i.rvalid) begin
            if (!pending) begin
               report_protocol("rvalid arrived without a pending request");
            end else begin
               // Both events sit half a cycle off their edges, so edges = samples - 1
               latency = sample - acc_sample - 1;
               if (latency != WAIT_STATES + 3) begin
                  $display("** Error %s latency at 0x%h: expected %0d, actual %0d",
                           test_name(exp_test), exp_addr, WAIT_STATES + 3, latency);
                  value_errs_o++;
               end
               if (!exp_write && iob_resp_i.rdata !== exp_rdata) begin
                  $display("** Error %s rdata at 0x%h: expected 0x%h, actual 0x%h",
                           test_name(exp_test), exp_addr, exp_rdata, iob_resp_i.rdata);
                  value_errs_o++;
               end
               pending = 1'b0;
               resp_cnt_o++;
            end
            if (!iob_resp_i.ready) report_protocol("rvalid high while ready is low");
            if (prev_rvalid) report_protocol("rvalid held longer than one cycle");
         end else if (pending && iob_resp_i.ready) begin
            report_protocol("ready returned before the response");
         end
         // Acceptance happens at the next rising edge
         if (iob_req_i.avalid && iob_resp_i.ready) begin
            pending    = 1'b1;
            acc_sample = sample;
            exp_addr   = iob_req_i.addr;
            exp_write  = |iob_req_i.wstrb;
            exp_test   = test_id_i;
            exp_rdata  = ref_access(iob_req_i.addr, iob_req_i.wdata, iob_req_i.wstrb);
         end
         prev_rvalid = iob_resp_i.rvalid;
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_iob_apb.sv
`timescale 1ns/1ns
`default_nettype none

module tb_iob_apb;

   localparam int          WAIT_STATES = 2;
   localparam int          N_REGS      = 16;
   localparam int          N_OPS       = 200;
   localparam logic [31:0] SEED        = 32'h38af3911;
   localparam int          RST_CYCLES  = 10;
   localparam int          DRV_DELAY   = 2;
   localparam int          N_DIRECTED  = 3 * N_REGS + 20;
   localparam int          N_TOTAL     = N_DIRECTED + N_OPS;
   // Back to back, one transfer takes WAIT_STATES+4 edges from acceptance to acceptance
   localparam int          TIMEOUT     = RST_CYCLES + N_TOTAL * (WAIT_STATES + 4) + 50;
   localparam int          AW_RAND     = $clog2(2 * N_REGS);  // Reaches past the bank

   logic                   clk = 1'b0;
   logic                   rst_n;
   iob_apb_pkg::iob_req_t  iob_req;
   iob_apb_pkg::iob_resp_t iob_resp;
   logic [2:0]             test_id;
   logic [31:0]            lfsr;
   int                     value_errs;
   int                     proto_errs;
   int                     resp_cnt;
   int                     cycles;

   always #20 clk = ~clk;

   iob_apb_subsys #(
      .WAIT_STATES(WAIT_STATES),
      .N_REGS     (N_REGS)
   ) i_dut (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .iob_req_i (iob_req),
      .iob_resp_o(iob_resp)
   );

   tb_checker #(
      .WAIT_STATES(WAIT_STATES),
      .N_REGS     (N_REGS)
   ) i_checker (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .iob_req_i   (iob_req),
      .iob_resp_i  (iob_resp),
      .test_id_i   (test_id),
      .value_errs_o(value_errs),
      .proto_errs_o(proto_errs),
      .resp_cnt_o  (resp_cnt)
   );

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);  // One step per bit
         bits = {bits[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [31:0] fill(input logic [31:0] addr);
      return (addr * 32'h9e3779b1) ^ 32'h5a5aa5a5;
   endfunction

   // Holds the request until the DUT takes it and returns just after the accepting edge
   task automatic issue(input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] wstrb);
      iob_req.avalid = 1'b1;
      iob_req.addr   = addr;
      iob_req.wdata  = wdata;
      iob_req.wstrb  = wstrb;
      @(negedge clk);
      while (!iob_resp.ready) @(negedge clk);
      @(posedge clk);
      #DRV_DELAY;
      iob_req.avalid = 1'b0;
   endtask

   task automatic run_directed();
      logic [31:0] addr;
      logic [3:0]  part_strb [4];
      logic [31:0] oob_addr [4];
      part_strb = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
      oob_addr  = '{N_REGS * 4, (N_REGS + 3) * 4, (2 * N_REGS - 1) * 4, 32'hfffffffc};
      test_id = 3'd1;
      for (int i = 0; i < N_REGS; i++) issue(i * 4, '0, 4'h0);
      test_id = 3'd2;
      for (int i = 0; i < N_REGS; i++) begin
         addr = i * 4;
         issue(addr, fill(addr), 4'hf);
         issue(addr, '0, 4'h0);
      end
      test_id = 3'd3;
      for (int i = 0; i < 4; i++) begin
         addr = (i + 4) * 4;
         issue(addr, ~fill(addr), part_strb[i]);
         issue(addr, '0, 4'h0);
      end
      test_id = 3'd4;
      for (int i = 0; i < 4; i++) begin
         issue(oob_addr[i], fill(oob_addr[i]), 4'hf);
         issue(oob_addr[i], '0, 4'h0);
         issue(oob_addr[i] & (N_REGS * 4 - 1), '0, 4'h0);  // In-range alias stays intact
      end
   endtask

   task automatic run_random();
      logic [31:0] op;
      logic [31:0] waddr;
      logic [31:0] strb;
      logic [31:0] data;
      test_id = 3'd5;
      for (int n = 0; n < N_OPS; n++) begin
         take_bits(1, op);
         take_bits(AW_RAND, waddr);
         take_bits(4, strb);
         take_bits(32, data);
         if (!op[0]) strb = '0;  // Read
         else if (strb[3:0] == 4'h0) strb = 32'hf;
         issue(waddr << 2, data, strb[3:0]);
      end
   endtask

   task automatic finish_run(input logic timed_out);
      $display("Summary: %0d responses, %0d value errors, %0d protocol errors, %0d timeouts",
               resp_cnt, value_errs, proto_errs, timed_out);
      if (!timed_out && value_errs == 0 && proto_errs == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   endtask

   initial begin
      rst_n   = 1'b0;
      iob_req = '0;
      test_id = '0;
      lfsr    = SEED;
      repeat (RST_CYCLES) @(posedge clk);
      #DRV_DELAY;
      rst_n = 1'b1;
      run_directed();
      run_random();
      wait (resp_cnt == N_TOTAL);
      repeat (2) @(posedge clk);
      finish_run(1'b0);
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Error: timeout after %0d cycles with %0d of %0d responses seen",
               cycles, resp_cnt, N_TOTAL);
      finish_run(1'b1);
   end

endmodule

`default_nettype wire

//--- src.f
design/iob_apb_pkg.sv
design/apb_wait_timer.sv
design/apb_regfile.sv
design/iob2apb.sv
design/iob_apb_subsys.sv
verif/tb_checker.sv
verif/tb_iob_apb.sv

//--- Makefile
SIM        := verilator
TOP        := tb_iob_apb
FILELIST   := src.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
